//--- Bender.yml
package:
  name: udp_rx

sources:
  - verilog/udp_rx_pkg.sv
  - verilog/rx_sync_fifo.sv
  - verilog/udp_header_parser.sv
  - verilog/udp_frame_writer.sv
  - verilog/udp_rx.sv
  - target: test
    files:
      - tests/udp_rx_chk.sv
      - tests/udp_rx_tb.sv

//--- filelist.f
verilog/udp_rx_pkg.sv
verilog/rx_sync_fifo.sv
verilog/udp_header_parser.sv
verilog/udp_frame_writer.sv
verilog/udp_rx.sv
tests/udp_rx_chk.sv
tests/udp_rx_tb.sv

//--- tests/udp_rx_chk.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rx_chk
  import udp_rx_pkg::*;
(
  input logic          mac_clk,
  input logic          mac_rst,
  input logic          rx_valid,
  input payload_word_t rx_word,
  input logic          rx_ack,
  input logic          overrun_pending
);

  int unsigned assert_fails = 0;

  // the FIFO head holds until it is acked
  head_stable: assert property (@(posedge mac_clk) disable iff (mac_rst)
    rx_valid && !rx_ack |=> rx_valid && $stable(rx_word))
  else begin
    $error("rx_word changed while rx_valid was high and rx_ack low");
    assert_fails++;
  end

  overrun_reset: assert property (@(posedge mac_clk) mac_rst |=> !overrun_pending)
  else begin
    $error("overrun_pending high after reset");
    assert_fails++;
  end

  // an overrun word closes its frame
  overrun_eof: assert property (@(posedge mac_clk) disable iff (mac_rst)
    rx_valid && rx_word.overrun |-> rx_word.eof)
  else begin
    $error("overrun word without eof");
    assert_fails++;
  end

endmodule

`default_nettype wire

//--- tests/udp_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rx_tb
  import udp_rx_pkg::*;
();

  localparam int PKT_DEPTH  = 16;
  localparam int PKT_AF     = 12;
  localparam int CTRL_DEPTH = 8;
  localparam int CTRL_AF    = 6;
  localparam int GAP        = 8;

  localparam logic [31:0] SEED       = 32'h6dbd_a13a;
  localparam mac_addr_t   LOCAL_MAC  = 48'h02_00_00_00_00_01;
  localparam ipv4_addr_t  LOCAL_IP   = 32'h0a00_0002;
  localparam udp_port_t   LOCAL_PORT = 16'h1234;
  localparam mac_beat_t   IDLE_BEAT  = '0;

  // mode bits are enable, phy_up, bad end, hold ack
  localparam logic [3:0] M_NORM = 4'b1100;
  localparam logic [3:0] M_BAD  = 4'b1110;
  localparam logic [3:0] M_OFF  = 4'b0100;
  localparam logic [3:0] M_DOWN = 4'b1000;
  localparam logic [3:0] M_HOLD = 4'b1101;

  typedef struct packed {
    logic [7:0]  words;
    mac_addr_t   dst_mac;
    logic [15:0] eth_type;
    logic [7:0]  ver_ihl;
    logic [7:0]  proto;
    ipv4_addr_t  dst_ip;
    udp_port_t   dst_port;
    logic [3:0]  mode;
    logic        accept;
  } frame_row_t;

  logic           mac_clk = 1'b0;
  logic           mac_rst;
  mac_beat_t      rx_beat;
  logic           phy_up;
  local_config_t  local_cfg;
  logic           rx_valid;
  payload_word_t  rx_word;
  udp_endpoints_t rx_endpoints;
  logic           rx_ack;
  logic           overrun_ack;
  logic           overrun_pending;

  frame_row_t     rows[$];
  string          names[$];
  logic [7:0]     fb[0:255];
  payload_word_t  got_words[$];
  payload_word_t  exp_words[$];
  udp_endpoints_t got_eps[$];
  udp_endpoints_t exp_ep;
  logic [31:0]    rng;
  logic           hold_ack;
  int             errors;
  int             checks;
  int             cycle_count = 0;
  int             limit_cycles = 0;

  udp_rx #(
    .PKT_DEPTH        (PKT_DEPTH),
    .PKT_ALMOST_FULL  (PKT_AF),
    .CTRL_DEPTH       (CTRL_DEPTH),
    .CTRL_ALMOST_FULL (CTRL_AF)
  ) udp_rx_inst (
    .mac_clk         (mac_clk),
    .mac_rst         (mac_rst),
    .rx_beat         (rx_beat),
    .phy_up          (phy_up),
    .local_cfg       (local_cfg),
    .rx_valid        (rx_valid),
    .rx_word         (rx_word),
    .rx_endpoints    (rx_endpoints),
    .rx_ack          (rx_ack),
    .overrun_ack     (overrun_ack),
    .overrun_pending (overrun_pending)
  );

  bind udp_rx udp_rx_chk chk_inst (
    .mac_clk         (mac_clk),
    .mac_rst         (mac_rst),
    .rx_valid        (rx_valid),
    .rx_word         (rx_word),
    .rx_ack          (rx_ack),
    .overrun_pending (overrun_pending)
  );

  always #20 mac_clk = ~mac_clk;

  always @(posedge mac_clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (limit_cycles > 0 && cycle_count >= limit_cycles);
    $display("timeout: no progress after %0d cycles", limit_cycles);
    $display("Test failures found");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic frame_row_t make_row(input int words, input mac_addr_t mac,
                                          input logic [15:0] et, input logic [7:0] vi,
                                          input logic [7:0] pr, input ipv4_addr_t dip,
                                          input udp_port_t dp, input logic [3:0] mode,
                                          input logic acc);
    frame_row_t r;
    r.words    = 8'(words);
    r.dst_mac  = mac;
    r.eth_type = et;
    r.ver_ihl  = vi;
    r.proto    = pr;
    r.dst_ip   = dip;
    r.dst_port = dp;
    r.mode     = mode;
    r.accept   = acc;
    return r;
  endfunction

  function automatic void add_row(input string name, input frame_row_t r);
    names.push_back(name);
    rows.push_back(r);
  endfunction

  task automatic fill_table();
    add_row("unicast", make_row(4, LOCAL_MAC, ETH_TYPE_IPV4, IPV4_VER_IHL, IP_PROTO_UDP,
                                LOCAL_IP, LOCAL_PORT, M_NORM, 1'b1));
    add_row("broadcast", make_row(3, MAC_BROADCAST, ETH_TYPE_IPV4, IPV4_VER_IHL,
                                  IP_PROTO_UDP, LOCAL_IP, LOCAL_PORT, M_NORM, 1'b1));
    add_row("mcast in group", make_row(5, 48'h01_00_5e_01_01_05, ETH_TYPE_IPV4,
                                       IPV4_VER_IHL, IP_PROTO_UDP, 32'he001_0105,
                                       LOCAL_PORT, M_NORM, 1'b1));
    add_row("mcast outside group", make_row(3, 48'h01_00_5e_02_03_05, ETH_TYPE_IPV4,
                                            IPV4_VER_IHL, IP_PROTO_UDP, 32'he002_0305,
                                            LOCAL_PORT, M_NORM, 1'b0));
    add_row("wrong mac", make_row(3, 48'h02_00_00_00_00_99, ETH_TYPE_IPV4, IPV4_VER_IHL,
                                  IP_PROTO_UDP, LOCAL_IP, LOCAL_PORT, M_NORM, 1'b0));
    add_row("not ipv4", make_row(3, LOCAL_MAC, 16'h86dd, IPV4_VER_IHL, IP_PROTO_UDP,
                                 LOCAL_IP, LOCAL_PORT, M_NORM, 1'b0));
    add_row("ip options", make_row(3, LOCAL_MAC, ETH_TYPE_IPV4, 8'h46, IP_PROTO_UDP,
                                   LOCAL_IP, LOCAL_PORT, M_NORM, 1'b0));
    add_row("not udp", make_row(3, LOCAL_MAC, ETH_TYPE_IPV4, IPV4_VER_IHL, 8'h06,
                                LOCAL_IP, LOCAL_PORT, M_NORM, 1'b0));
    add_row("wrong port", make_row(3, LOCAL_MAC, ETH_TYPE_IPV4, IPV4_VER_IHL, IP_PROTO_UDP,
                                   LOCAL_IP, 16'h4321, M_NORM, 1'b0));
    add_row("unicast after drops", make_row(1, LOCAL_MAC, ETH_TYPE_IPV4, IPV4_VER_IHL,
                                            IP_PROTO_UDP, LOCAL_IP, LOCAL_PORT, M_NORM, 1'b1));
    add_row("bad end", make_row(3, LOCAL_MAC, ETH_TYPE_IPV4, IPV4_VER_IHL, IP_PROTO_UDP,
                                LOCAL_IP, LOCAL_PORT, M_BAD, 1'b1));
    add_row("enable low", make_row(3, LOCAL_MAC, ETH_TYPE_IPV4, IPV4_VER_IHL, IP_PROTO_UDP,
                                   LOCAL_IP, LOCAL_PORT, M_OFF, 1'b0));
    add_row("phy down", make_row(3, LOCAL_MAC, ETH_TYPE_IPV4, IPV4_VER_IHL, IP_PROTO_UDP,
                                 LOCAL_IP, LOCAL_PORT, M_DOWN, 1'b0));
    add_row("overrun", make_row(20, LOCAL_MAC, ETH_TYPE_IPV4, IPV4_VER_IHL, IP_PROTO_UDP,
                                LOCAL_IP, LOCAL_PORT, M_HOLD, 1'b1));
    add_row("after overrun", make_row(6, LOCAL_MAC, ETH_TYPE_IPV4, IPV4_VER_IHL,
                                      IP_PROTO_UDP, LOCAL_IP, LOCAL_PORT, M_NORM, 1'b1));
  endtask

  // one clock: sample the FIFO head, ack it, drive the next beat
  task automatic tick(input mac_beat_t beat);
    @(negedge mac_clk);
    if (rx_valid && !hold_ack) begin
      got_words.push_back(rx_word);
      if (rx_word.eof) begin
        got_eps.push_back(rx_endpoints);
      end
      rx_ack = 1'b1;
    end else begin
      rx_ack = 1'b0;
    end
    rx_beat = beat;
  endtask

  // frame bytes and the expected words and endpoint record
  task automatic build_frame(input frame_row_t r);
    int nw;
    int nbytes;
    int i;
    int j;
    int b;
    int last;
    ipv4_addr_t src_ip;
    udp_port_t src_port;
    payload_word_t w;
    nw = int'(r.words);
    nbytes = 8 * (nw + 6);
    for (i = 0; i < nbytes; i++) begin
      rng = xorshift(rng);
      fb[i] = rng[7:0];
    end
    rng = xorshift(rng);
    src_ip = rng;
    rng = xorshift(rng);
    src_port = rng[15:0];
    for (i = 0; i < 6; i++) begin
      fb[i] = r.dst_mac[47-8*i -: 8];
    end
    fb[12] = r.eth_type[15:8];
    fb[13] = r.eth_type[7:0];
    fb[14] = r.ver_ihl;
    fb[23] = r.proto;
    for (i = 0; i < 4; i++) begin
      fb[26+i] = src_ip[31-8*i -: 8];
      fb[30+i] = r.dst_ip[31-8*i -: 8];
    end
    fb[34] = src_port[15:8];
    fb[35] = src_port[7:0];
    fb[36] = r.dst_port[15:8];
    fb[37] = r.dst_port[7:0];
    exp_ep = '{dst_port: r.dst_port, dst_ip: r.dst_ip, src_port: src_port, src_ip: src_ip};
    exp_words.delete();
    if (r.accept) begin
      last = nw - 1;
      // nothing is read, so the word that meets the almost-full level ends the frame
      if (r.mode[0] && nw > PKT_AF) begin
        last = PKT_AF;
      end
      for (j = 0; j <= last; j++) begin
        w = '0;
        for (b = 0; b < 8; b++) begin
          w.data[63-8*b -: 8] = fb[42+8*j+b];
        end
        w.eof     = (j == last);
        w.overrun = (j == last) && (j < nw - 1);
        w.bad     = (j == nw - 1) && r.mode[1];
        exp_words.push_back(w);
      end
    end
  endtask

  task automatic send_frame(input frame_row_t r);
    int nbeats;
    int k;
    int i;
    mac_beat_t b;
    nbeats = int'(r.words) + 6;
    for (k = 0; k < nbeats; k++) begin
      b = '0;
      for (i = 0; i < 8; i++) begin
        b.data[8*i +: 8] = fb[8*k+i];
      end
      b.valid = 8'hff;
      b.good  = (k == nbeats - 1) && !r.mode[1];
      b.bad   = (k == nbeats - 1) && r.mode[1];
      tick(b);
    end
  endtask

  task automatic run_row(input int n);
    frame_row_t r;
    int i;
    int errs;
    r = rows[n];
    errs = 0;
    got_words.delete();
    got_eps.delete();
    build_frame(r);
    local_cfg.enable = r.mode[3];
    phy_up = r.mode[2];
    hold_ack = r.mode[0];
    send_frame(r);
    for (i = 0; i < GAP; i++) begin
      tick(IDLE_BEAT);
    end
    if (r.mode[0]) begin
      checks++;
      if (overrun_pending !== 1'b1) begin
        $display("Fail row %0d: overrun_pending got %h expected 1", n, overrun_pending);
        errs++;
      end
      for (i = 0; i < 4; i++) begin
        tick(IDLE_BEAT);
      end
      checks++;
      if (overrun_pending !== 1'b1) begin
        $display("Fail row %0d: overrun_pending got %h expected 1", n, overrun_pending);
        errs++;
      end
      overrun_ack = 1'b1;
      tick(IDLE_BEAT);
      overrun_ack = 1'b0;
      hold_ack = 1'b0;
    end
    while (got_words.size() < exp_words.size()) begin
      tick(IDLE_BEAT);
    end
    while (rx_valid) begin
      tick(IDLE_BEAT);
    end
    checks++;
    if (got_words.size() != exp_words.size()) begin
      $display("row %0d delivered %0d payload words where %0d were expected",
               n, got_words.size(), exp_words.size());
      errs++;
    end else begin
      for (i = 0; i < got_words.size(); i++) begin
        checks++;
        if (got_words[i] !== exp_words[i]) begin
          $display("Fail row %0d word %0d: rx_word got %h expected %h",
                   n, i, got_words[i], exp_words[i]);
          errs++;
        end
      end
    end
    checks++;
    if (got_eps.size() != (r.accept ? 1 : 0)) begin
      $display("row %0d delivered %0d endpoint records where %0d were expected",
               n, got_eps.size(), r.accept ? 1 : 0);
      errs++;
    end else if (r.accept && got_eps[0] !== exp_ep) begin
      $display("Fail row %0d: rx_endpoints got %h expected %h", n, got_eps[0], exp_ep);
      errs++;
    end
    checks++;
    if (overrun_pending !== 1'b0) begin
      $display("Fail row %0d: overrun_pending got %h expected 0", n, overrun_pending);
      errs++;
    end
    $display("row %0d %s: %0d words, %s", n, names[n], got_words.size(),
             (errs == 0) ? "ok" : "FAILED");
    errors += errs;
  endtask

  initial begin
    int total_beats;
    mac_rst     = 1'b1;
    rx_beat     = IDLE_BEAT;
    phy_up      = 1'b1;
    rx_ack      = 1'b0;
    overrun_ack = 1'b0;
    hold_ack    = 1'b0;
    local_cfg   = '{enable: 1'b1, mac: LOCAL_MAC, ip: LOCAL_IP, port: LOCAL_PORT,
                    mc_group: 32'he001_0100, mc_mask: 32'hffff_ff00};
    rng    = SEED;
    errors = 0;
    checks = 0;
    fill_table();
    total_beats = 0;
    foreach (rows[n]) begin
      total_beats += int'(rows[n].words) + 6 + GAP;
    end
    limit_cycles = total_beats * 4 + 200;
    repeat (3) @(negedge mac_clk);
    mac_rst = 1'b0;
    checks++;
    if (rx_valid !== 1'b0) begin
      $display("Fail after reset: rx_valid got %h expected 0", rx_valid);
      errors++;
    end
    checks++;
    if (overrun_pending !== 1'b0) begin
      $display("Fail after reset: overrun_pending got %h expected 0", overrun_pending);
      errors++;
    end
    foreach (rows[n]) begin
      run_row(n);
    end
    tick(IDLE_BEAT);
    tick(IDLE_BEAT);
    errors += udp_rx_inst.chk_inst.assert_fails;
    $display("%0d rows, %0d checks, %0d errors, %0d assertion failures", rows.size(),
             checks, errors, udp_rx_inst.chk_inst.assert_fails);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/rx_sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rx_sync_fifo #(
  parameter int WIDTH       = 8,
  parameter int DEPTH       = 16,
  parameter int ALMOST_FULL = 12
) (
  input  logic             mac_clk,
  input  logic             mac_rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             almost_full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_wr;
  logic             do_rd;

  // pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_wr       = wr_en && (count != CW'(DEPTH));
  assign do_rd       = rd_en && (count != '0);
  assign empty       = (count == '0);
  assign almost_full = (count >= CW'(ALMOST_FULL));
  // first word fall through, head is always on rd_data
  assign rd_data     = mem[rd_ptr];

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CW'(do_wr) - CW'(do_rd);
    end
  end

endmodule

`default_nettype wire

//--- verilog/udp_frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

module udp_frame_writer
  import udp_rx_pkg::*;
(
  input  logic           mac_clk,
  input  logic           mac_rst,
  input  data_word_t     payload,
  input  logic           payload_valid,
  input  logic           frame_good,
  input  logic           frame_bad,
  input  udp_endpoints_t endpoints,
  input  logic           pkt_almost_full,
  input  logic           ctrl_almost_full,
  input  logic           overrun_ack,
  output logic           pkt_wr_en,
  output payload_word_t  pkt_wr_data,
  output logic           ctrl_wr_en,
  output udp_endpoints_t ctrl_wr_data,
  output logic           overrun_pending
);

  localparam logic [1:0] W_RUN  = 2'd0;
  localparam logic [1:0] W_OVER = 2'd1;
  localparam logic [1:0] W_WAIT = 2'd2;

  logic [1:0] state;
  logic       first_word;
  logic       in_frame;
  logic       in_frame_nxt;
  logic       frame_end;
  logic       fifo_tight;
  logic       overrun_hit;

  assign frame_end   = frame_good || frame_bad;
  assign fifo_tight  = pkt_almost_full || ctrl_almost_full;
  // the word offered while a FIFO is tight still goes in, tagged
  assign overrun_hit = payload_valid && fifo_tight && (state == W_RUN);

  // a frame is open from its first word until its end strobe
  assign in_frame_nxt = (in_frame || payload_valid) && !frame_end;

  assign pkt_wr_en           = payload_valid && (state == W_RUN);
  assign pkt_wr_data.overrun = overrun_hit;
  assign pkt_wr_data.bad     = frame_bad;
  assign pkt_wr_data.eof     = frame_end || overrun_hit;
  assign pkt_wr_data.data    = payload;

  // one record per frame, on the first word written
  assign ctrl_wr_en   = pkt_wr_en && first_word;
  assign ctrl_wr_data = endpoints;

  assign overrun_pending = (state == W_OVER);

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state      <= W_RUN;
      first_word <= 1'b1;
      in_frame   <= 1'b0;
    end else begin
      in_frame <= in_frame_nxt;
      if (pkt_wr_en) begin
        first_word <= pkt_wr_data.eof;
      end
      case (state)
        W_RUN: begin
          if (overrun_hit) begin
            state <= W_OVER;
          end
        end
        // drop everything until the application has seen the overrun
        W_OVER: begin
          if (overrun_ack) begin
            state <= in_frame_nxt ? W_WAIT : W_RUN;
          end
        end
        // skip the rest of the frame that was cut short
        W_WAIT: begin
          if (frame_end) begin
            state <= W_RUN;
          end
        end
        default: state <= W_RUN;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/udp_header_parser.sv
`timescale 1ns/1ps
`default_nettype none

module udp_header_parser
  import udp_rx_pkg::*;
(
  input  logic           mac_clk,
  input  logic           mac_rst,
  input  mac_beat_t      rx_beat,
  input  logic           phy_up,
  input  local_config_t  local_cfg,
  output data_word_t     payload,
  output logic           payload_valid,
  output logic           frame_good,
  output logic           frame_bad,
  output udp_endpoints_t endpoints
);

  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_HDR2 = 3'd1;
  localparam logic [2:0] S_HDR3 = 3'd2;
  localparam logic [2:0] S_HDR4 = 3'd3;
  localparam logic [2:0] S_HDR5 = 3'd4;
  localparam logic [2:0] S_HDR6 = 3'd5;
  localparam logic [2:0] S_DATA = 3'd6;

  logic [2:0]  state;
  logic        accept;
  mac_beat_t   beat_z;
  data_word_t  data_r;
  logic        good_r;
  logic        bad_r;
  logic        frame_end_r;
  logic        in_data;

  mac_addr_t   dst_mac;
  logic [15:0] eth_type;
  logic [7:0]  ver_ihl;
  logic [7:0]  ip_proto;
  ipv4_addr_t  src_ip;
  ipv4_addr_t  dst_ip;
  udp_port_t   src_port;
  udp_port_t   dst_port;
  logic        mac_ok;
  logic        ip_ok;

  // input register, then a second stage for words that straddle two beats
  always_ff @(posedge mac_clk) begin
    beat_z.data <= rx_beat.data;
    data_r      <= beat_z.data;
    if (mac_rst) begin
      beat_z.valid <= '0;
      beat_z.good  <= 1'b0;
      beat_z.bad   <= 1'b0;
      good_r       <= 1'b0;
      bad_r        <= 1'b0;
    end else begin
      beat_z.valid <= rx_beat.valid;
      beat_z.good  <= rx_beat.good;
      beat_z.bad   <= rx_beat.bad;
      good_r       <= beat_z.good;
      bad_r        <= beat_z.bad;
    end
  end

  // header fields, byte swapped so the first wire byte is the msb
  assign dst_mac  = {beat_z.data[7:0], beat_z.data[15:8], beat_z.data[23:16],
                     beat_z.data[31:24], beat_z.data[39:32], beat_z.data[47:40]};
  assign eth_type = {beat_z.data[39:32], beat_z.data[47:40]};
  assign ver_ihl  = beat_z.data[55:48];
  assign ip_proto = beat_z.data[63:56];
  assign src_ip   = {beat_z.data[23:16], beat_z.data[31:24],
                     beat_z.data[39:32], beat_z.data[47:40]};
  // bytes 30..31 sit in the previous beat
  assign dst_ip   = {data_r[55:48], data_r[63:56], beat_z.data[7:0], beat_z.data[15:8]};
  assign src_port = {beat_z.data[23:16], beat_z.data[31:24]};
  assign dst_port = {beat_z.data[39:32], beat_z.data[47:40]};

  assign mac_ok = (dst_mac == local_cfg.mac) || (dst_mac == MAC_BROADCAST) ||
                  (dst_mac[47:24] == MAC_MCAST_PREFIX);
  // unicast to us, or a group we subscribed to
  assign ip_ok  = (dst_ip == local_cfg.ip) ||
                  ((dst_ip & local_cfg.mc_mask) == (local_cfg.mc_group & local_cfg.mc_mask));

  assign frame_end_r = good_r || bad_r;
  assign in_data     = accept && (state == S_DATA);

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state  <= S_IDLE;
      accept <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          accept <= 1'b1;
          if (&beat_z.valid && phy_up) begin
            state <= S_HDR2;
            if (!mac_ok) begin
              accept <= 1'b0;
              state  <= S_DATA;
            end
          end
        end
        S_HDR2: begin
          if (eth_type != ETH_TYPE_IPV4 || ver_ihl != IPV4_VER_IHL) begin
            accept <= 1'b0;
            state  <= S_DATA;
          end else begin
            state <= S_HDR3;
          end
        end
        S_HDR3: begin
          if (ip_proto != IP_PROTO_UDP) begin
            accept <= 1'b0;
            state  <= S_DATA;
          end else begin
            state <= S_HDR4;
          end
        end
        // ip checksum is not checked
        S_HDR4: state <= S_HDR5;
        S_HDR5: begin
          if (dst_port != local_cfg.port || !ip_ok) begin
            accept <= 1'b0;
            state  <= S_DATA;
          end else begin
            state <= S_HDR6;
          end
        end
        // udp length and checksum are ignored
        S_HDR6: state <= S_DATA;
        S_DATA: begin
          if (frame_end_r) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
      if (!local_cfg.enable) begin
        accept <= 1'b0;
      end
    end
  end

  // endpoint capture, overwritten by every frame that reaches these words
  always_ff @(posedge mac_clk) begin
    if (state == S_HDR4) begin
      endpoints.src_ip <= src_ip;
    end
    if (state == S_HDR5) begin
      endpoints.dst_ip   <= dst_ip;
      endpoints.src_port <= src_port;
      endpoints.dst_port <= dst_port;
    end
  end

  // payload starts at byte 42, which is lane 2 of beat 5
  // one word per beat from beat 6 up to the end strobe, so the last
  // word may carry no payload bytes at all
  always_ff @(posedge mac_clk) begin
    payload <= {data_r[23:16], data_r[31:24], data_r[39:32], data_r[47:40],
                data_r[55:48], data_r[63:56], beat_z.data[7:0], beat_z.data[15:8]};
    if (mac_rst) begin
      payload_valid <= 1'b0;
      frame_good    <= 1'b0;
      frame_bad     <= 1'b0;
    end else begin
      payload_valid <= in_data && !frame_end_r;
      frame_good    <= in_data && beat_z.good;
      frame_bad     <= in_data && beat_z.bad;
    end
  end

endmodule

`default_nettype wire

//--- verilog/udp_rx.sv
`timescale 1ns/1ps
`default_nettype none

module udp_rx
  import udp_rx_pkg::*;
#(
  parameter int PKT_DEPTH        = 64,
  parameter int PKT_ALMOST_FULL  = 48,
  parameter int CTRL_DEPTH       = 16,
  parameter int CTRL_ALMOST_FULL = 12
) (
  input  logic           mac_clk,
  input  logic           mac_rst,
  input  mac_beat_t      rx_beat,
  input  logic           phy_up,
  input  local_config_t  local_cfg,
  output logic           rx_valid,
  output payload_word_t  rx_word,
  output udp_endpoints_t rx_endpoints,
  input  logic           rx_ack,
  input  logic           overrun_ack,
  output logic           overrun_pending
);

  data_word_t     payload;
  logic           payload_valid;
  logic           frame_good;
  logic           frame_bad;
  udp_endpoints_t endpoints;

  logic           pkt_wr_en;
  payload_word_t  pkt_wr_data;
  logic           pkt_almost_full;
  logic           pkt_empty;

  logic           ctrl_wr_en;
  udp_endpoints_t ctrl_wr_data;
  logic           ctrl_almost_full;
  logic           ctrl_empty;
  logic           ctrl_rd_en;

  udp_header_parser parser_inst (
    .mac_clk       (mac_clk),
    .mac_rst       (mac_rst),
    .rx_beat       (rx_beat),
    .phy_up        (phy_up),
    .local_cfg     (local_cfg),
    .payload       (payload),
    .payload_valid (payload_valid),
    .frame_good    (frame_good),
    .frame_bad     (frame_bad),
    .endpoints     (endpoints)
  );

  udp_frame_writer writer_inst (
    .mac_clk          (mac_clk),
    .mac_rst          (mac_rst),
    .payload          (payload),
    .payload_valid    (payload_valid),
    .frame_good       (frame_good),
    .frame_bad        (frame_bad),
    .endpoints        (endpoints),
    .pkt_almost_full  (pkt_almost_full),
    .ctrl_almost_full (ctrl_almost_full),
    .overrun_ack      (overrun_ack),
    .pkt_wr_en        (pkt_wr_en),
    .pkt_wr_data      (pkt_wr_data),
    .ctrl_wr_en       (ctrl_wr_en),
    .ctrl_wr_data     (ctrl_wr_data),
    .overrun_pending  (overrun_pending)
  );

  rx_sync_fifo #(
    .WIDTH       ($bits(payload_word_t)),
    .DEPTH       (PKT_DEPTH),
    .ALMOST_FULL (PKT_ALMOST_FULL)
  ) pkt_fifo_inst (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (pkt_wr_en),
    .wr_data     (pkt_wr_data),
    .rd_en       (rx_ack),
    .rd_data     (rx_word),
    .empty       (pkt_empty),
    .almost_full (pkt_almost_full)
  );

  rx_sync_fifo #(
    .WIDTH       ($bits(udp_endpoints_t)),
    .DEPTH       (CTRL_DEPTH),
    .ALMOST_FULL (CTRL_ALMOST_FULL)
  ) ctrl_fifo_inst (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (ctrl_wr_en),
    .wr_data     (ctrl_wr_data),
    .rd_en       (ctrl_rd_en),
    .rd_data     (rx_endpoints),
    .empty       (ctrl_empty),
    .almost_full (ctrl_almost_full)
  );

  assign rx_valid   = !pkt_empty;
  // the endpoint record retires with the last word of its frame
  assign ctrl_rd_en = rx_ack && rx_valid && rx_word.eof && !ctrl_empty;

endmodule

`default_nettype wire

//--- verilog/udp_rx_pkg.sv
`default_nettype none

package udp_rx_pkg;

  // basic widths
  typedef logic [63:0] data_word_t;
  typedef logic [7:0]  byte_mask_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] udp_port_t;

  // protocol constants, all in network order
  localparam logic [15:0] ETH_TYPE_IPV4    = 16'h0800;
  localparam logic [7:0]  IPV4_VER_IHL     = 8'h45;
  localparam logic [7:0]  IP_PROTO_UDP     = 8'h11;
  localparam mac_addr_t   MAC_BROADCAST    = {48{1'b1}};
  localparam logic [23:0] MAC_MCAST_PREFIX = 24'h01005e;

  // one beat from the MAC, byte 0 of the frame in bits 7:0
  typedef struct packed {
    data_word_t data;
    byte_mask_t valid;
    logic       good;
    logic       bad;
  } mac_beat_t;

  // per-frame record held in the control FIFO
  typedef struct packed {
    udp_port_t  dst_port;
    ipv4_addr_t dst_ip;
    udp_port_t  src_port;
    ipv4_addr_t src_ip;
  } udp_endpoints_t;

  // packet FIFO word, first payload byte in bits 63:56
  typedef struct packed {
    logic       overrun;
    logic       bad;
    logic       eof;
    data_word_t data;
  } payload_word_t;

  // static station setup
  typedef struct packed {
    logic       enable;
    mac_addr_t  mac;
    ipv4_addr_t ip;
    udp_port_t  port;
    ipv4_addr_t mc_group;
    ipv4_addr_t mc_mask;
  } local_config_t;

endpackage

`default_nettype wire
